// ==== logic/muldiv_params.svh ====
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// ##############################
// datapath sizing
// ##############################

// operand and result width of the execute stage.
`define MULDIV_XLEN 64

// width of the tag that travels with each request.
`define MULDIV_TAG_W 4

// the divider retires one quotient bit per iteration.
`define MULDIV_DIV_STEPS `MULDIV_XLEN

`endif

// ==== logic/muldiv_pkg.sv ====
`include "muldiv_params.svh"

package muldiv_pkg;

	// ##############################
	// operation encoding
	// ##############################

	typedef enum logic [2:0] {
		OP_MUL  = 3'd0,
		OP_MULW = 3'd1,
		OP_DIV  = 3'd2,
		OP_DIVU = 3'd3,
		OP_REM  = 3'd4,
		OP_REMU = 3'd5
	} muldiv_op_t;

	// ##############################
	// payloads
	// ##############################

	typedef struct packed {
		muldiv_op_t               op;
		logic [`MULDIV_XLEN-1:0]  a;
		logic [`MULDIV_XLEN-1:0]  b;
		logic [`MULDIV_TAG_W-1:0] tag;
	} muldiv_req_t;

	typedef struct packed {
		logic                     is_signed;
		logic                     want_rem; // remainder instead of quotient.
		logic                     is_word; // result is sign extended from bit 31.
		logic [`MULDIV_TAG_W-1:0] tag;
	} muldiv_ctl_t;

	typedef struct packed {
		logic [`MULDIV_XLEN-1:0]  result;
		logic [`MULDIV_TAG_W-1:0] tag;
	} muldiv_rsp_t;

endpackage

// ==== logic/pipe_skid.sv ====
`timescale 1ns/10ps

module pipe_skid #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic     spare_valid;
	payload_t spare_data;
	logic     in_fire;
	logic     main_free;

	assign in_ready  = ~spare_valid; // comes straight from a flop.
	assign in_fire   = in_valid & in_ready;
	assign main_free = ~out_valid | out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid   <= 1'b0;
			spare_valid <= 1'b0;
		end else if (flush) begin
			out_valid   <= 1'b0;
			spare_valid <= 1'b0;
		end else if (main_free) begin
			out_valid   <= spare_valid | in_fire; // the spare entry drains first.
			spare_valid <= 1'b0;
		end else if (in_fire) begin
			spare_valid <= 1'b1; // the output is stalled so the new beat is parked.
		end
	end

	always_ff @(posedge clk) begin
		if (main_free & (spare_valid | in_fire)) begin
			out_data <= spare_valid ? spare_data : in_data;
		end
		if (~main_free & in_fire) begin
			spare_data <= in_data;
		end
	end

	// a stalled output keeps its payload until the consumer takes it.
	assert property (@(posedge clk) disable iff (!arst_n || flush)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== logic/muldiv_dispatch.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module muldiv_dispatch
	import muldiv_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    in_valid,
	input  muldiv_req_t             in_req,
	input  logic                    div_busy,
	input  logic                    en,
	output logic                    in_ready,
	output logic                    mul_valid,
	output logic                    div_start,
	output logic [`MULDIV_XLEN-1:0] opa,
	output logic [`MULDIV_XLEN-1:0] opb,
	output muldiv_ctl_t             ctl
);

	localparam logic [1:0] MUL_DEPTH = 2'd2; // pipeline stages inside mul_pipe.

	logic [1:0]  mul_cnt;
	logic        is_mul;
	logic        mul_empty;
	logic        can_mul;
	logic        can_div;
	logic        in_fire;
	muldiv_ctl_t dec_ctl;

	// ##############################
	// decode
	// ##############################

	always_comb begin
		dec_ctl     = '0;
		dec_ctl.tag = in_req.tag;
		is_mul      = 1'b0;
		case (in_req.op)
			OP_MUL: begin
				is_mul = 1'b1;
			end
			OP_MULW: begin
				is_mul          = 1'b1;
				dec_ctl.is_word = 1'b1;
			end
			OP_DIV: begin
				dec_ctl.is_signed = 1'b1;
			end
			OP_REM: begin
				dec_ctl.is_signed = 1'b1;
				dec_ctl.want_rem  = 1'b1;
			end
			OP_REMU: begin
				dec_ctl.want_rem = 1'b1;
			end
			default: begin
				dec_ctl.is_signed = 1'b0; // divu and the unused codes.
			end
		endcase
	end

	// ##############################
	// issue and ordering
	// ##############################

	assign mul_empty = ~mul_valid & (mul_cnt == 2'd0);
	assign can_mul   = (~mul_valid | en) & ~div_busy & ~div_start;
	assign can_div   = mul_empty & ~div_busy & ~div_start;
	assign in_ready  = is_mul ? can_mul : can_div;
	assign in_fire   = in_valid & in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mul_valid <= 1'b0;
			div_start <= 1'b0;
			mul_cnt   <= 2'd0;
		end else if (flush) begin
			mul_valid <= 1'b0;
			div_start <= 1'b0;
			mul_cnt   <= 2'd0;
		end else begin
			div_start <= in_fire & ~is_mul;
			if (in_fire & is_mul) begin
				mul_valid <= 1'b1;
			end else if (en) begin
				mul_valid <= 1'b0;
			end
			if (en) begin // counts enabled cycles until the multiplier has drained.
				if (mul_valid) begin
					mul_cnt <= MUL_DEPTH;
				end else if (mul_cnt != 2'd0) begin
					mul_cnt <= mul_cnt - 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			opa <= in_req.a;
			opb <= in_req.b;
			ctl <= dec_ctl;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(div_start && mul_valid));

endmodule

// ==== logic/mul_pipe.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module mul_pipe
	import muldiv_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    en,
	input  logic                    in_valid,
	input  logic [`MULDIV_XLEN-1:0] opa,
	input  logic [`MULDIV_XLEN-1:0] opb,
	input  muldiv_ctl_t             in_ctl,
	output logic                    out_valid,
	output logic [`MULDIV_XLEN-1:0] product,
	output muldiv_ctl_t             out_ctl
);

	localparam int HALF = `MULDIV_XLEN / 2;

	logic                      s1_valid;
	muldiv_ctl_t               s1_ctl;
	logic [`MULDIV_XLEN-1:0]   pp_ll;
	logic [`MULDIV_XLEN-1:0]   pp_lh;
	logic [`MULDIV_XLEN-1:0]   pp_hl;
	logic [`MULDIV_XLEN-1:0]   pp_hh;
	logic [2*`MULDIV_XLEN-1:0] full_sum;

	// ##############################
	// valid pipeline
	// ##############################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (flush) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (en) begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// ##############################
	// partial products and sum
	// ##############################

	// the low half of a product does not depend on signedness so all products are unsigned.
	always_ff @(posedge clk) begin
		if (en & in_valid) begin
			pp_ll  <= opa[HALF-1:0] * opb[HALF-1:0];
			pp_lh  <= opa[HALF-1:0] * opb[`MULDIV_XLEN-1:HALF];
			pp_hl  <= opa[`MULDIV_XLEN-1:HALF] * opb[HALF-1:0];
			pp_hh  <= opa[`MULDIV_XLEN-1:HALF] * opb[`MULDIV_XLEN-1:HALF];
			s1_ctl <= in_ctl;
		end
		if (en & s1_valid) begin
			product <= full_sum[`MULDIV_XLEN-1:0];
			out_ctl <= s1_ctl;
		end
	end

	assign full_sum = {pp_hh, pp_ll}
		+ {{HALF{1'b0}}, pp_lh, {HALF{1'b0}}}
		+ {{HALF{1'b0}}, pp_hl, {HALF{1'b0}}};

endmodule

// ==== logic/div_iter.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module div_iter
	import muldiv_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    start,
	input  logic [`MULDIV_XLEN-1:0] opa,
	input  logic [`MULDIV_XLEN-1:0] opb,
	input  muldiv_ctl_t             in_ctl,
	input  logic                    ack,
	output logic                    busy,
	output logic                    done,
	output logic [`MULDIV_XLEN-1:0] value,
	output muldiv_ctl_t             out_ctl
);

	localparam int XLEN  = `MULDIV_XLEN;
	localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS + 1);
	localparam logic [CNT_W-1:0] STEPS = CNT_W'(`MULDIV_DIV_STEPS);
	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DONE
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [XLEN-1:0]  quo; // dividend bits shift out at the top as quotient bits enter.
	logic [XLEN-1:0]  rem;
	logic [XLEN-1:0]  dvs;
	logic             q_neg;
	logic             r_neg;
	logic             dbz;
	logic             ovf;
	logic             a_neg;
	logic             b_neg;
	logic [XLEN-1:0]  a_mag;
	logic [XLEN-1:0]  b_mag;
	logic [XLEN:0]    shifted;
	logic [XLEN:0]    trial;
	logic [XLEN-1:0]  q_fix;
	logic [XLEN-1:0]  r_fix;

	assign a_neg = in_ctl.is_signed & opa[XLEN-1];
	assign b_neg = in_ctl.is_signed & opb[XLEN-1];
	assign a_mag = a_neg ? -opa : opa;
	assign b_mag = b_neg ? -opb : opb;

	assign shifted = {rem, quo[XLEN-1]};
	assign trial   = shifted - {1'b0, dvs}; // top bit set means the divisor did not fit.

	// ##############################
	// control
	// ##############################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else if (flush) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_RUN;
						cnt   <= STEPS;
					end
				end
				S_RUN: begin
					cnt <= cnt - CNT_W'(1);
					if (cnt == CNT_W'(1)) begin
						state <= S_DONE;
					end
				end
				S_DONE: begin
					if (ack) begin
						state <= S_IDLE; // the result stage has taken the value.
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// ##############################
	// datapath
	// ##############################

	always_ff @(posedge clk) begin
		if (start) begin
			quo     <= a_mag;
			rem     <= '0;
			dvs     <= b_mag;
			q_neg   <= a_neg ^ b_neg;
			r_neg   <= a_neg; // remainder takes the sign of the dividend.
			dbz     <= (opb == '0);
			ovf     <= in_ctl.is_signed & (opa == MOST_NEG) & (&opb);
			out_ctl <= in_ctl;
		end else if (state == S_RUN) begin
			rem <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
			quo <= {quo[XLEN-2:0], ~trial[XLEN]};
		end
	end

	// with a zero divisor the remainder register ends up holding the dividend magnitude.
	assign q_fix = dbz ? '1 : (ovf ? MOST_NEG : (q_neg ? -quo : quo));
	assign r_fix = ovf ? '0 : (r_neg ? -rem : rem);

	assign value = out_ctl.want_rem ? r_fix : q_fix;
	assign done  = (state == S_DONE);
	assign busy  = (state != S_IDLE);

	// dispatch must hold a new divide back until the last one is acknowledged.
	assert property (@(posedge clk) disable iff (!arst_n) !(start && busy));

endmodule

// ==== logic/muldiv_result.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module muldiv_result
	import muldiv_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    mul_valid,
	input  logic [`MULDIV_XLEN-1:0] mul_value,
	input  muldiv_ctl_t             mul_ctl,
	input  logic                    div_done,
	input  logic [`MULDIV_XLEN-1:0] div_value,
	input  muldiv_ctl_t             div_ctl,
	input  logic                    rsp_ready,
	output logic                    en,
	output logic                    div_ack,
	output muldiv_rsp_t             rsp,
	output logic                    rsp_valid
);

	muldiv_ctl_t             sel_ctl;
	logic [`MULDIV_XLEN-1:0] sel_value;
	muldiv_rsp_t             fmt_rsp;
	logic                    fmt_valid;
	logic                    skid_ready;

	// only one unit can hold a finished result at a time.
	assign fmt_valid = mul_valid | div_done;
	assign sel_ctl   = div_done ? div_ctl : mul_ctl;
	assign sel_value = div_done ? div_value : mul_value;

	always_comb begin
		fmt_rsp.tag = sel_ctl.tag;
		if (sel_ctl.is_word) begin
			fmt_rsp.result = {{(`MULDIV_XLEN-32){sel_value[31]}}, sel_value[31:0]};
		end else begin
			fmt_rsp.result = sel_value;
		end
	end

	assign en      = skid_ready; // freezes the multiplier under back-pressure.
	assign div_ack = skid_ready & div_done;

	pipe_skid #(
		.payload_t (muldiv_rsp_t)
	) rsp_skid_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.in_valid  (fmt_valid),
		.in_data   (fmt_rsp),
		.in_ready  (skid_ready),
		.out_valid (rsp_valid),
		.out_data  (rsp),
		.out_ready (rsp_ready)
	);

	assert property (@(posedge clk) disable iff (!arst_n) !(mul_valid && div_done));

endmodule

// ==== logic/muldiv_unit.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module muldiv_unit (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    flush,
	input  logic                    req_valid,
	input  muldiv_pkg::muldiv_req_t req,
	output logic                    req_ready,
	output logic                    rsp_valid,
	output muldiv_pkg::muldiv_rsp_t rsp,
	input  logic                    rsp_ready
);

	logic                    skid_valid;
	logic                    skid_ready;
	muldiv_pkg::muldiv_req_t skid_req;
	logic                    mul_in_valid;
	logic                    div_start;
	logic [`MULDIV_XLEN-1:0] opa;
	logic [`MULDIV_XLEN-1:0] opb;
	muldiv_pkg::muldiv_ctl_t disp_ctl;
	logic                    en;
	logic                    mul_out_valid;
	logic [`MULDIV_XLEN-1:0] mul_product;
	muldiv_pkg::muldiv_ctl_t mul_ctl;
	logic                    div_busy;
	logic                    div_done;
	logic                    div_ack;
	logic [`MULDIV_XLEN-1:0] div_value;
	muldiv_pkg::muldiv_ctl_t div_ctl;

	// ##############################
	// front end
	// ##############################

	pipe_skid #(
		.payload_t (muldiv_pkg::muldiv_req_t)
	) req_skid_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.in_valid  (req_valid),
		.in_data   (req),
		.in_ready  (req_ready),
		.out_valid (skid_valid),
		.out_data  (skid_req),
		.out_ready (skid_ready)
	);

	muldiv_dispatch dispatch_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.in_valid  (skid_valid),
		.in_req    (skid_req),
		.div_busy  (div_busy),
		.en        (en),
		.in_ready  (skid_ready),
		.mul_valid (mul_in_valid),
		.div_start (div_start),
		.opa       (opa),
		.opb       (opb),
		.ctl       (disp_ctl)
	);

	// ##############################
	// execution units
	// ##############################

	mul_pipe mul_pipe_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.en        (en),
		.in_valid  (mul_in_valid),
		.opa       (opa),
		.opb       (opb),
		.in_ctl    (disp_ctl),
		.out_valid (mul_out_valid),
		.product   (mul_product),
		.out_ctl   (mul_ctl)
	);

	div_iter div_iter_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.flush   (flush),
		.start   (div_start),
		.opa     (opa),
		.opb     (opb),
		.in_ctl  (disp_ctl),
		.ack     (div_ack),
		.busy    (div_busy),
		.done    (div_done),
		.value   (div_value),
		.out_ctl (div_ctl)
	);

	muldiv_result result_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.mul_valid (mul_out_valid),
		.mul_value (mul_product),
		.mul_ctl   (mul_ctl),
		.div_done  (div_done),
		.div_value (div_value),
		.div_ctl   (div_ctl),
		.rsp_ready (rsp_ready),
		.en        (en),
		.div_ack   (div_ack),
		.rsp       (rsp),
		.rsp_valid (rsp_valid)
	);

endmodule

// ==== bench/muldiv_unit_tb.sv ====
`timescale 1ns/10ps
`include "muldiv_params.svh"

module muldiv_unit_tb
	import muldiv_pkg::*;
;

	localparam logic [31:0] SEED = 32'h1f550865;
	localparam int NUM_VEC = 30;
	localparam int SEND_LIMIT = 500;
	localparam int DRAIN_LIMIT = 2000;
	localparam int READY_HIGH = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_LOW = 2;
	localparam logic [`MULDIV_XLEN-1:0] MOST_NEG = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

	typedef struct packed {
		muldiv_op_t              op;
		logic [`MULDIV_XLEN-1:0] a;
		logic [`MULDIV_XLEN-1:0] b;
		logic [`MULDIV_XLEN-1:0] exp;
	} vec_t;

	// ##############################
	// directed vectors
	// ##############################

	localparam vec_t VECTORS [NUM_VEC] = '{
		'{OP_MUL,  64'd7,                  64'd6,          64'd42},
		'{OP_MUL,  -64'sd3,                64'd5,          -64'sd15},
		'{OP_MUL,  -64'sd4,                -64'sd8,        64'd32},
		'{OP_MUL,  64'h1_0000_0001,        64'h1_0000_0001, 64'h2_0000_0001},
		'{OP_MULW, 64'h1_0000,             64'h8000,       64'hffff_ffff_8000_0000},
		'{OP_MULW, 64'd3,                  64'd4,          64'd12},
		'{OP_MULW, -64'sd1,                64'd2,          -64'sd2},
		'{OP_MULW, 64'h1234_5678_0000_0003, 64'd2,         64'd6},
		'{OP_DIV,  64'd20,                 64'd6,          64'd3},
		'{OP_DIV,  -64'sd20,               64'd6,          -64'sd3},
		'{OP_DIV,  64'd20,                 -64'sd6,        -64'sd3},
		'{OP_DIV,  -64'sd20,               -64'sd6,        64'd3},
		'{OP_REM,  64'd20,                 64'd6,          64'd2},
		'{OP_REM,  -64'sd20,               64'd6,          -64'sd2},
		'{OP_REM,  64'd20,                 -64'sd6,        64'd2},
		'{OP_REM,  -64'sd20,               -64'sd6,        -64'sd2},
		'{OP_DIVU, 64'd20,                 64'd6,          64'd3},
		'{OP_DIVU, -64'sd20,               64'd6,          64'h2aaa_aaaa_aaaa_aaa7},
		'{OP_DIVU, 64'd20,                 -64'sd6,        64'd0},
		'{OP_DIVU, -64'sd6,                -64'sd20,       64'd1},
		'{OP_REMU, 64'd20,                 64'd6,          64'd2},
		'{OP_REMU, -64'sd20,               64'd6,          64'd2},
		'{OP_REMU, 64'd20,                 -64'sd6,        64'd20},
		'{OP_REMU, -64'sd20,               -64'sd6,        -64'sd20},
		'{OP_DIV,  64'd20,                 64'd0,          -64'sd1},
		'{OP_DIVU, 64'd20,                 64'd0,          -64'sd1},
		'{OP_REM,  -64'sd20,               64'd0,          -64'sd20},
		'{OP_REMU, 64'd20,                 64'd0,          64'd20},
		'{OP_DIV,  64'h8000_0000_0000_0000, -64'sd1,       64'h8000_0000_0000_0000},
		'{OP_REM,  64'h8000_0000_0000_0000, -64'sd1,       64'd0}
	};

	logic                     clk;
	logic                     arst_n;
	logic                     flush;
	logic                     req_valid;
	muldiv_req_t              req;
	logic                     req_ready;
	logic                     rsp_valid;
	muldiv_rsp_t              rsp;
	logic                     rsp_ready;
	muldiv_rsp_t              exp_q[$];
	logic [`MULDIV_TAG_W-1:0] tag_next;
	logic [31:0]              stim_seed;
	logic [31:0]              ready_seed;
	int                       ready_mode;
	int                       ready_now;
	int                       mismatch_count;
	int                       fail_count;
	int                       rsp_count;

	muldiv_unit muldiv_unit_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ##############################
	// reference model and checks
	// ##############################

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [`MULDIV_XLEN-1:0] ref_result(input muldiv_op_t op,
			input logic [`MULDIV_XLEN-1:0] a, input logic [`MULDIV_XLEN-1:0] b);
		logic [`MULDIV_XLEN-1:0]        prod;
		logic signed [`MULDIV_XLEN-1:0] sa;
		logic signed [`MULDIV_XLEN-1:0] sb;
		logic signed [`MULDIV_XLEN-1:0] sq;
		logic signed [`MULDIV_XLEN-1:0] sr;
		logic                           ovf;
		prod = a * b;
		sa = a;
		sb = b;
		ovf = (a == MOST_NEG) && (b == '1);
		sq = '0;
		sr = '0;
		if (b != '0 && !ovf) begin
			sq = sa / sb; // plain signed division away from the special cases.
			sr = sa % sb;
		end
		case (op)
			OP_MUL: ref_result = prod;
			OP_MULW: ref_result = {{(`MULDIV_XLEN-32){prod[31]}}, prod[31:0]};
			OP_DIV: ref_result = (b == '0) ? '1 : (ovf ? MOST_NEG : sq);
			OP_DIVU: ref_result = (b == '0) ? '1 : a / b;
			OP_REM: ref_result = (b == '0) ? a : (ovf ? '0 : sr);
			OP_REMU: ref_result = (b == '0) ? a : a % b;
			default: ref_result = '0;
		endcase
	endfunction

	task automatic check_rsp(input muldiv_rsp_t got, input muldiv_rsp_t exp);
		if (got.tag !== exp.tag) begin
			mismatch_count++;
			$display("mismatch rsp.tag got %h expected %h", got.tag, exp.tag);
		end
		if (got.result !== exp.result) begin
			mismatch_count++;
			$display("mismatch rsp.result got %h expected %h", got.result, exp.result);
		end
	endtask

	task automatic check_ctrl(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("mismatches %0d, other errors %0d, responses checked %0d",
			mismatch_count, fail_count, rsp_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	// responses are taken on the edge after a negedge that sees valid and ready.
	always @(negedge clk) begin
		if (arst_n && rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				fail_count++;
				$display("response with tag %h arrived when none was expected", rsp.tag);
			end else begin
				check_rsp(rsp, exp_q.pop_front());
				rsp_count++;
			end
		end
	end

	always @(posedge clk) begin
		ready_now = ready_mode;
		#2;
		if (ready_now == READY_RANDOM) begin
			ready_seed = xorshift32(ready_seed);
			rsp_ready = (ready_seed[1:0] != 2'b00); // low about one cycle in four.
		end else begin
			rsp_ready = (ready_now == READY_HIGH);
		end
	end

	// ##############################
	// stimulus tasks
	// ##############################

	task automatic skip_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_req(input muldiv_op_t op, input logic [`MULDIV_XLEN-1:0] a,
			input logic [`MULDIV_XLEN-1:0] b, input logic [`MULDIV_XLEN-1:0] exp);
		muldiv_rsp_t expected;
		int          waited;
		req.op = op;
		req.a = a;
		req.b = b;
		req.tag = tag_next;
		req_valid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!req_ready && waited < SEND_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!req_ready) begin
			fail_count++;
			$display("request with tag %h was never accepted", tag_next);
		end else begin
			expected.result = exp;
			expected.tag = tag_next;
			exp_q.push_back(expected);
			tag_next++;
		end
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < limit) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (exp_q.size() != 0) begin
			fail_count++;
			$display("%0d responses still missing after %0d cycles", exp_q.size(), limit);
		end
	endtask

	task automatic draw_word(output logic [`MULDIV_XLEN-1:0] w);
		logic [31:0] hi;
		stim_seed = xorshift32(stim_seed);
		hi = stim_seed;
		stim_seed = xorshift32(stim_seed);
		w = {hi, stim_seed};
	endtask

	task automatic random_phase(input int count);
		muldiv_op_t              op;
		logic [31:0]             pick;
		logic [`MULDIV_XLEN-1:0] a;
		logic [`MULDIV_XLEN-1:0] b;
		int                      n;
		for (n = 0; n < count; n++) begin
			stim_seed = xorshift32(stim_seed);
			pick = stim_seed;
			op = muldiv_op_t'(3'(pick % 6));
			draw_word(a);
			draw_word(b);
			if (pick[6:4] == 3'd0) begin
				a = MOST_NEG;
			end
			case (pick[10:8])
				3'd0: b = '0;
				3'd1: b = '1;
				3'd2: b = {{(`MULDIV_XLEN-8){1'b0}}, b[7:0]}; // small divisors.
				3'd3: b = {{(`MULDIV_XLEN-8){1'b1}}, b[7:0]};
				default: begin
				end
			endcase
			send_req(op, a, b, ref_result(op, a, b));
			if (pick[13:12] == 2'd0) begin
				skip_cycles(1);
			end
		end
	endtask

	task automatic flush_phase();
		int n;
		ready_mode = READY_LOW;
		skip_cycles(2);
		send_req(OP_MUL, 64'd11, 64'd13, 64'd143);
		send_req(OP_DIV, 64'd1000, 64'd7, 64'd142);
		send_req(OP_MULW, 64'd5, 64'd9, 64'd45);
		skip_cycles(8); // the divide is now iterating and a multiply is parked.
		exp_q.delete();
		flush = 1'b1;
		skip_cycles(1);
		flush = 1'b0;
		ready_mode = READY_HIGH;
		for (n = 0; n < 100; n++) begin
			@(negedge clk);
			check_ctrl("rsp_valid", rsp_valid, 1'b0);
		end
		@(posedge clk);
		#2;
		send_req(OP_REM, -64'sd1000, 64'd7, -64'sd6);
		send_req(OP_MUL, 64'd12, 64'd12, 64'd144);
		wait_drain(DRAIN_LIMIT);
	endtask

	// ##############################
	// main sequence
	// ##############################

	initial begin
		int i;
		arst_n = 1'b0;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b1;
		ready_mode = READY_HIGH;
		tag_next = '0;
		stim_seed = SEED;
		ready_seed = SEED;
		mismatch_count = 0;
		fail_count = 0;
		rsp_count = 0;
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(negedge clk);
		check_ctrl("rsp_valid", rsp_valid, 1'b0);
		check_ctrl("req_ready", req_ready, 1'b1);
		@(posedge clk);
		#2;
		for (i = 0; i < NUM_VEC; i++) begin
			send_req(VECTORS[i].op, VECTORS[i].a, VECTORS[i].b, VECTORS[i].exp);
		end
		wait_drain(DRAIN_LIMIT);
		ready_mode = READY_RANDOM;
		random_phase(80);
		ready_mode = READY_HIGH;
		wait_drain(DRAIN_LIMIT);
		flush_phase();
		end_run();
	end

endmodule

// ==== muldiv_unit.f ====
+incdir+logic
logic/muldiv_pkg.sv
logic/pipe_skid.sv
logic/muldiv_dispatch.sv
logic/mul_pipe.sv
logic/div_iter.sv
logic/muldiv_result.sv
logic/muldiv_unit.sv
bench/muldiv_unit_tb.sv
